// File: nandCtrl_config.svh
`ifndef NANDCTRL_CONFIG_SVH
`define NANDCTRL_CONFIG_SVH

// ========================================
// field widths
// ========================================
`define NC_OPCODE_WIDTH   6
`define NC_ID_WIDTH       5
`define NC_OPERAND_WIDTH  16
`define NC_PRIM_WIDTH     8

// target ID shared by all control commands
`define NC_TARGET_CTRL    5'b00101

// control opcodes
`define NC_OP_PI_RESET    6'b110010
`define NC_OP_PO_RESET    6'b110000
`define NC_OP_DELAY       6'b101000

// primitive manager slot indices
`define NC_PRIM_PI_RESET  4
`define NC_PRIM_PO_RESET  3

`endif

// File: nandCtrlPkg.sv
`default_nettype none
`include "nandCtrl_config.svh"

package nandCtrlPkg;

    // ========================================
    // vector types
    // ========================================
    typedef logic [`NC_OPCODE_WIDTH-1:0]  opcodeT;
    typedef logic [`NC_ID_WIDTH-1:0]      idT;
    typedef logic [`NC_OPERAND_WIDTH-1:0] operandT;
    // one bit per primitive manager slot
    typedef logic [`NC_PRIM_WIDTH-1:0]    primVecT;

    // ========================================
    // bus structs
    // ========================================
    typedef struct packed {
        opcodeT  opcode;
        idT      targetId;
        idT      sourceId;
        operandT operand;
    } cmdT;

    // one-hot executor start, with the issuing source
    typedef struct packed {
        logic piReset;
        logic poReset;
        logic delay;
        idT   sourceId;
    } triggerT;

    typedef struct packed {
        logic lastStep;
        idT   sourceId;
    } doneT;

    // executor FSM states
    typedef enum logic [1:0] {
        resetIdle,
        resetIssue,
        resetWait
    } resetStateT;

    typedef enum logic {
        delayIdle,
        delayCount
    } delayStateT;

endpackage

`default_nettype wire

// File: commandDecoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "nandCtrl_config.svh"

module commandDecoder (
    input  wire                       iSystemClock,
    input  wire                       arstN,
    input  wire  nandCtrlPkg::cmdT    cmd,
    input  wire                       cmdValid,
    input  wire                       cmdReady,
    output nandCtrlPkg::triggerT      trig,
    output logic                      start,
    output logic                      error,
    output nandCtrlPkg::operandT      operand,
    output logic                      pending
);

    nandCtrlPkg::cmdT cmdReg;
    logic             held;
    logic             accept;
    logic             targetHit;

    assign accept = cmdValid & cmdReady;

    // one cycle only, cmdReady drops while held
    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            held <= 1'b0;
        end else begin
            held <= accept;
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (accept) begin
            cmdReg <= cmd;
        end
    end

    // ========================================
    // decode of the held command
    // ========================================
    assign targetHit = (cmdReg.targetId == `NC_TARGET_CTRL);

    always_comb begin
        trig          = '0;
        trig.sourceId = cmdReg.sourceId;
        error         = 1'b0;
        if (held) begin
            if (!targetHit) begin
                error = 1'b1;
            end else begin
                case (cmdReg.opcode)
                    `NC_OP_PI_RESET: trig.piReset = 1'b1;
                    `NC_OP_PO_RESET: trig.poReset = 1'b1;
                    `NC_OP_DELAY:    trig.delay   = 1'b1;
                    default:         error        = 1'b1;
                endcase
            end
        end
    end

    // no start for rejected commands
    assign start   = trig.piReset | trig.poReset | trig.delay;
    assign operand = cmdReg.operand;
    assign pending = held;

endmodule

`default_nettype wire

// File: phyResetExecutor.sv
`timescale 1ns/1ps
`default_nettype none

module phyResetExecutor #(
    parameter int primBit = 4
) (
    input  wire                          iSystemClock,
    input  wire                          arstN,
    input  wire                          trigger,
    input  wire  nandCtrlPkg::primVecT   pmReady,
    input  wire  nandCtrlPkg::primVecT   pmLastStep,
    output nandCtrlPkg::primVecT         pmCommand,
    output logic                         busy,
    output logic                         lastStep
);

    nandCtrlPkg::resetStateT state;
    nandCtrlPkg::resetStateT nextState;

    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            state <= nandCtrlPkg::resetIdle;
        end else begin
            state <= nextState;
        end
    end

    // ========================================
    // next state
    // ========================================
    always_comb begin
        nextState = state;
        case (state)
            nandCtrlPkg::resetIdle: begin
                if (trigger) begin
                    nextState = nandCtrlPkg::resetIssue;
                end
            end
            nandCtrlPkg::resetIssue: begin
                // hold the primitive until our slot is ready
                if (pmReady[primBit]) begin
                    nextState = nandCtrlPkg::resetWait;
                end
            end
            nandCtrlPkg::resetWait: begin
                if (lastStep) begin
                    nextState = nandCtrlPkg::resetIdle;
                end
            end
            default: nextState = nandCtrlPkg::resetIdle;
        endcase
    end

    // ========================================
    // outputs
    // ========================================
    always_comb begin
        pmCommand          = '0;
        pmCommand[primBit] = (state == nandCtrlPkg::resetIssue);
    end

    assign lastStep = (state == nandCtrlPkg::resetWait) & pmLastStep[primBit];
    assign busy     = (state != nandCtrlPkg::resetIdle);

endmodule

`default_nettype wire

// File: delayExecutor.sv
`timescale 1ns/1ps
`default_nettype none

module delayExecutor (
    input  wire                          iSystemClock,
    input  wire                          arstN,
    input  wire                          trigger,
    input  wire  nandCtrlPkg::operandT   operand,
    output logic                         busy,
    output logic                         lastStep
);

    nandCtrlPkg::delayStateT state;
    nandCtrlPkg::operandT    count;
    logic                    countZero;

    assign countZero = (count == '0);

    // ========================================
    // countdown FSM
    // ========================================
    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            state <= nandCtrlPkg::delayIdle;
            count <= '0;
        end else begin
            case (state)
                nandCtrlPkg::delayIdle: begin
                    if (trigger) begin
                        count <= operand;
                        state <= nandCtrlPkg::delayCount;
                    end
                end
                nandCtrlPkg::delayCount: begin
                    // finish on the zero cycle itself
                    if (countZero) begin
                        state <= nandCtrlPkg::delayIdle;
                    end else begin
                        count <= count - nandCtrlPkg::operandT'(1);
                    end
                end
                default: begin
                    state <= nandCtrlPkg::delayIdle;
                end
            endcase
        end
    end

    // zero operand completes the cycle after trigger
    assign lastStep = (state == nandCtrlPkg::delayCount) & countZero;
    assign busy     = (state != nandCtrlPkg::delayIdle);

endmodule

`default_nettype wire

// File: completionMerger.sv
`timescale 1ns/1ps
`default_nettype none

module completionMerger (
    input  wire                          iSystemClock,
    input  wire                          arstN,
    input  wire                          pending,
    input  wire  nandCtrlPkg::triggerT   trig,
    input  wire                          busyPi,
    input  wire                          busyPo,
    input  wire                          busyDelay,
    input  wire                          lastPi,
    input  wire                          lastPo,
    input  wire                          lastDelay,
    input  wire  nandCtrlPkg::primVecT   cmdPi,
    input  wire  nandCtrlPkg::primVecT   cmdPo,
    output logic                         cmdReady,
    output nandCtrlPkg::primVecT         pmCommand,
    output nandCtrlPkg::doneT            done
);

    nandCtrlPkg::idT srcIdReg;
    logic            anyTrig;
    logic            anyBusy;

    assign anyTrig = trig.piReset | trig.poReset | trig.delay;
    assign anyBusy = busyPi | busyPo | busyDelay;

    // ========================================
    // source ID of the running command
    // ========================================
    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            srcIdReg <= '0;
        end else if (anyTrig) begin
            srcIdReg <= trig.sourceId;
        end
    end

    // ========================================
    // host side and primitive side
    // ========================================

    // error path only holds pending, so ready returns after one cycle
    assign cmdReady = ~(pending | anyBusy);

    // executors never drive the same slot
    assign pmCommand = cmdPi | cmdPo;

    always_comb begin
        done.lastStep = lastPi | lastPo | lastDelay;
        done.sourceId = srcIdReg;
    end

endmodule

`default_nettype wire

// File: nandCtrlTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "nandCtrl_config.svh"

module nandCtrlTop (
    input  wire                          iSystemClock,
    input  wire                          arstN,
    input  wire  nandCtrlPkg::cmdT       cmd,
    input  wire                          cmdValid,
    output logic                         cmdReady,
    output logic                         start,
    input  wire  nandCtrlPkg::primVecT   pmReady,
    input  wire  nandCtrlPkg::primVecT   pmLastStep,
    output nandCtrlPkg::primVecT         pmCommand,
    output nandCtrlPkg::doneT            done,
    output logic                         error
);

    nandCtrlPkg::triggerT trig;
    nandCtrlPkg::operandT operand;
    logic                 pending;
    nandCtrlPkg::primVecT cmdPi;
    nandCtrlPkg::primVecT cmdPo;
    logic                 busyPi;
    logic                 busyPo;
    logic                 busyDelay;
    logic                 lastPi;
    logic                 lastPo;
    logic                 lastDelay;

    // ========================================
    // decode
    // ========================================
    commandDecoder uDecoder (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .cmd          (cmd),
        .cmdValid     (cmdValid),
        .cmdReady     (cmdReady),
        .trig         (trig),
        .start        (start),
        .error        (error),
        .operand      (operand),
        .pending      (pending)
    );

    // ========================================
    // executors
    // ========================================
    phyResetExecutor #(.primBit(`NC_PRIM_PI_RESET)) uPiReset (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .trigger      (trig.piReset),
        .pmReady      (pmReady),
        .pmLastStep   (pmLastStep),
        .pmCommand    (cmdPi),
        .busy         (busyPi),
        .lastStep     (lastPi)
    );

    phyResetExecutor #(.primBit(`NC_PRIM_PO_RESET)) uPoReset (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .trigger      (trig.poReset),
        .pmReady      (pmReady),
        .pmLastStep   (pmLastStep),
        .pmCommand    (cmdPo),
        .busy         (busyPo),
        .lastStep     (lastPo)
    );

    delayExecutor uDelay (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .trigger      (trig.delay),
        .operand      (operand),
        .busy         (busyDelay),
        .lastStep     (lastDelay)
    );

    // ========================================
    // result
    // ========================================
    completionMerger uMerger (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .pending      (pending),
        .trig         (trig),
        .busyPi       (busyPi),
        .busyPo       (busyPo),
        .busyDelay    (busyDelay),
        .lastPi       (lastPi),
        .lastPo       (lastPo),
        .lastDelay    (lastDelay),
        .cmdPi        (cmdPi),
        .cmdPo        (cmdPo),
        .cmdReady     (cmdReady),
        .pmCommand    (pmCommand),
        .done         (done)
    );

endmodule

`default_nettype wire

// File: nandCtrl_chk.sv
`timescale 1ns/1ps
`default_nettype none
`include "nandCtrl_config.svh"

module nandCtrlChk (
    input wire                        iSystemClock,
    input wire                        arstN,
    input wire nandCtrlPkg::cmdT      cmd,
    input wire                        cmdValid,
    input wire                        cmdReady,
    input wire                        start,
    input wire nandCtrlPkg::primVecT  pmReady,
    input wire nandCtrlPkg::primVecT  pmLastStep,
    input wire nandCtrlPkg::primVecT  pmCommand,
    input wire nandCtrlPkg::doneT     done,
    input wire                        error
);

    int                   failCount = 0;
    int                   delayCnt;
    logic                 accept;
    logic                 knownCmd;
    logic                 delayCmd;
    logic                 heldGood;
    logic                 heldBad;
    logic                 heldPi;
    logic                 heldPo;
    logic                 piIssue;
    logic                 piWait;
    logic                 poIssue;
    logic                 poWait;
    logic                 delayRun;
    logic                 expBusy;
    logic                 expLast;
    nandCtrlPkg::primVecT expPm;
    nandCtrlPkg::idT      lastSrc;

    assign accept   = cmdValid & cmdReady;
    assign knownCmd = (cmd.targetId == `NC_TARGET_CTRL) && (cmd.opcode == `NC_OP_PI_RESET
                      || cmd.opcode == `NC_OP_PO_RESET || cmd.opcode == `NC_OP_DELAY);
    assign delayCmd = accept && knownCmd && (cmd.opcode == `NC_OP_DELAY);
    assign expLast  = (piWait & pmLastStep[`NC_PRIM_PI_RESET])
                    | (poWait & pmLastStep[`NC_PRIM_PO_RESET]) | (delayRun && delayCnt == 0);

    always_comb begin
        expPm                    = '0;
        expPm[`NC_PRIM_PI_RESET] = piIssue;
        expPm[`NC_PRIM_PO_RESET] = poIssue;
    end

    // ========================================
    // expected behaviour of the command path
    // ========================================
    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            {heldGood, heldBad, heldPi, heldPo} <= '0;
            {piIssue, piWait, poIssue, poWait, delayRun, expBusy} <= '0;
            delayCnt <= 0;
            lastSrc  <= '0;
        end else begin
            heldGood <= accept & knownCmd;
            heldBad  <= accept & ~knownCmd;
            // kind of the accepted command, the bus moves on right away
            heldPi   <= accept & knownCmd & (cmd.opcode == `NC_OP_PI_RESET);
            heldPo   <= accept & knownCmd & (cmd.opcode == `NC_OP_PO_RESET);
            if (accept) begin
                lastSrc <= cmd.sourceId;
            end
            // issue runs from the cycle after start up to the ready edge
            piIssue <= heldPi | (piIssue & ~pmReady[`NC_PRIM_PI_RESET]);
            piWait  <= (piIssue & pmReady[`NC_PRIM_PI_RESET])
                     | (piWait & ~pmLastStep[`NC_PRIM_PI_RESET]);
            poIssue <= heldPo | (poIssue & ~pmReady[`NC_PRIM_PO_RESET]);
            poWait  <= (poIssue & pmReady[`NC_PRIM_PO_RESET])
                     | (poWait & ~pmLastStep[`NC_PRIM_PO_RESET]);
            // operand+2 cycles from the accept cycle
            if (delayCmd) begin
                delayRun <= 1'b1;
                delayCnt <= int'(cmd.operand) + 1;
            end else if (delayRun) begin
                delayRun <= (delayCnt != 0);
                delayCnt <= delayCnt - 1;
            end
            expBusy <= accept | (expBusy & ~heldBad & ~expLast);
        end
    end

    // ========================================
    // assertions
    // ========================================
    startMatch: assert property (@(posedge iSystemClock) disable iff (!arstN)
        start == heldGood) else begin
        failCount++;
        $error("mismatch at %0t: start got %b expected %b", $time, start, heldGood);
    end

    errorMatch: assert property (@(posedge iSystemClock) disable iff (!arstN)
        error == heldBad) else begin
        failCount++;
        $error("mismatch at %0t: error got %b expected %b", $time, error, heldBad);
    end

    readyMatch: assert property (@(posedge iSystemClock) disable iff (!arstN)
        cmdReady == !expBusy) else begin
        failCount++;
        $error("mismatch at %0t: cmdReady got %b expected %b", $time, cmdReady, !expBusy);
    end

    primMatch: assert property (@(posedge iSystemClock) disable iff (!arstN)
        pmCommand == expPm) else begin
        failCount++;
        $error("mismatch at %0t: pmCommand got %h expected %h", $time, pmCommand, expPm);
    end

    lastMatch: assert property (@(posedge iSystemClock) disable iff (!arstN)
        done.lastStep == expLast) else begin
        failCount++;
        $error("mismatch at %0t: done.lastStep got %b expected %b", $time, done.lastStep,
               expLast);
    end

    idMatch: assert property (@(posedge iSystemClock) disable iff (!arstN)
        done.lastStep |-> done.sourceId == lastSrc) else begin
        failCount++;
        $error("mismatch at %0t: done.sourceId got %h expected %h", $time, done.sourceId,
               lastSrc);
    end

    quietAfterReset: assert property (@(posedge iSystemClock)
        $rose(arstN) |-> cmdReady && !start && !error && pmCommand == '0 && !done.lastStep)
        else begin
        failCount++;
        $error("outputs were active in the first cycle after reset at %0t", $time);
    end

endmodule

// checker sits inside every nandCtrlTop
bind nandCtrlTop nandCtrlChk uChk (.*);

`default_nettype wire

// File: nandCtrlTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "nandCtrl_config.svh"

module nandCtrlTb;

    localparam int          numCommands      = 40;
    localparam int          cyclesPerCommand = 80;
    localparam logic [31:0] seed             = 32'h5634e7ab;

    logic                 iSystemClock;
    logic                 arstN;
    nandCtrlPkg::cmdT     cmd;
    logic                 cmdValid;
    logic                 cmdReady;
    logic                 start;
    nandCtrlPkg::primVecT pmReady;
    nandCtrlPkg::primVecT pmLastStep;
    nandCtrlPkg::primVecT pmCommand;
    nandCtrlPkg::doneT    done;
    logic                 error;
    logic [31:0]          stimState;
    logic [31:0]          modelState;
    int                   accepted;

    nandCtrlTop uut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drawRandom(output logic [31:0] value);
        stimState = xorshift(stimState);
        value     = stimState;
    endtask

    // cmdValid stays high until the DUT takes the command
    task automatic sendCommand(input nandCtrlPkg::opcodeT opcode, input nandCtrlPkg::idT target,
                               input nandCtrlPkg::operandT operand);
        logic [31:0] r;
        drawRandom(r);
        cmd      <= '{opcode: opcode, targetId: target, sourceId: r[4:0], operand: operand};
        cmdValid <= 1'b1;
        do begin
            @(posedge iSystemClock);
        end while (!cmdReady);
        accepted++;
    endtask

    initial begin
        iSystemClock = 1'b0;
        forever #5 iSystemClock = ~iSystemClock;
    end

    // ========================================
    // primitive manager model
    // ========================================
    initial begin : primitiveManager
        int slot;
        pmReady    = '0;
        pmLastStep = '0;
        modelState = xorshift(seed);
        forever begin
            @(posedge iSystemClock);
            if (pmCommand[`NC_PRIM_PI_RESET] | pmCommand[`NC_PRIM_PO_RESET]) begin
                slot = pmCommand[`NC_PRIM_PI_RESET] ? `NC_PRIM_PI_RESET : `NC_PRIM_PO_RESET;
                modelState = xorshift(modelState);
                repeat (modelState[1:0]) @(posedge iSystemClock);
                pmReady[slot] <= 1'b1;
                @(posedge iSystemClock);
                pmReady <= '0;
                repeat (modelState[3:2]) @(posedge iSystemClock);
                pmLastStep[slot] <= 1'b1;
                @(posedge iSystemClock);
                pmLastStep <= '0;
            end
        end
    end

    // ========================================
    // stimulus and closing report
    // ========================================
    initial begin : stimulus
        logic [31:0]         r;
        nandCtrlPkg::opcodeT opcode;
        nandCtrlPkg::idT     target;
        arstN     = 1'b0;
        cmdValid  = 1'b0;
        cmd       = '0;
        stimState = seed;
        accepted  = 0;
        repeat (4) @(posedge iSystemClock);
        arstN <= 1'b1;
        for (int i = 0; i < numCommands; i++) begin
            drawRandom(r);
            target = `NC_TARGET_CTRL;
            case (r[2:0])
                3'd0, 3'd1: opcode = `NC_OP_PI_RESET;
                3'd2, 3'd3: opcode = `NC_OP_PO_RESET;
                3'd4, 3'd5: opcode = `NC_OP_DELAY;
                // no defined opcode starts with 0111
                3'd6: opcode = {4'b0111, r[9:8]};
                default: begin
                    opcode = `NC_OP_PI_RESET;
                    target = {r[12:10], 2'b10};
                end
            endcase
            sendCommand(opcode, target, nandCtrlPkg::operandT'(r[7:4]));
        end
        cmdValid <= 1'b0;
        do begin
            @(posedge iSystemClock);
        end while (!cmdReady);
        repeat (4) @(posedge iSystemClock);
        $display("commands accepted: %0d, assertion failures: %0d", accepted,
                 uut.uChk.failCount);
        if (uut.uChk.failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        #(numCommands * cyclesPerCommand * 10);
        $display("timeout: commands still running after %0d cycles",
                 numCommands * cyclesPerCommand);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
nandCtrlPkg.sv
commandDecoder.sv
phyResetExecutor.sv
delayExecutor.sv
completionMerger.sv
nandCtrlTop.sv
nandCtrl_chk.sv
nandCtrlTb.sv

// File: Bender.yml
package:
  name: nand_ctrl

sources:
  - include_dirs:
      - .
    files:
      - nandCtrlPkg.sv
      - commandDecoder.sv
      - phyResetExecutor.sv
      - delayExecutor.sv
      - completionMerger.sv
      - nandCtrlTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - nandCtrl_chk.sv
      - nandCtrlTb.sv
